/* logic/mips_isa_pkg.sv */
package mips_isa_pkg;

	////////////////////
	// field widths
	////////////////////

	// data path and instruction word
	localparam int word_w = 32;
	// register index, rs / rt / rd
	localparam int reg_addr_w = 5;
	localparam int num_regs = 2 ** reg_addr_w;
	localparam int opcode_w = 6;
	localparam int funct_w = 6;
	// i-type immediate, sign extended on use
	localparam int imm_w = 16;

	////////////////////
	// encodings
	////////////////////

	// major opcode, bits 31:26
	typedef enum logic [opcode_w-1:0] {
		op_rtype = 6'b000000,
		op_addiu = 6'b001001,
		op_lw    = 6'b100011,
		op_sw    = 6'b101011,
		op_beq   = 6'b000100,
		op_halt  = 6'b111111
	} opcode_e;

	// r-type function, bits 5:0
	typedef enum logic [funct_w-1:0] {
		fn_addu = 6'b100001,
		fn_subu = 6'b100011,
		fn_and  = 6'b100100,
		fn_or   = 6'b100101,
		fn_slt  = 6'b101010
	} funct_e;

	// execute FSM
	typedef enum logic [2:0] {
		st_wait_instr,
		st_execute,
		st_mem_req,
		st_mem_release,
		st_halted
	} exec_state_e;

endpackage

/* logic/mips_mem_pkg.sv */
package mips_mem_pkg;

	// unified memory, word addressed
	localparam int mem_depth = 256;
	// word index into the memory, also the PC width
	localparam int mem_addr_w = 8;

	// owner of the shared memory bus
	typedef enum logic [1:0] {
		req_none,
		req_fetch,
		req_lsu
	} requester_e;

endpackage

/* logic/mem_port_if.sv */
// four-phase memory port
// req/ack handshake, payload held stable while req is high
interface mem_port_if;
	logic req;
	logic ack;
	logic we;
	logic [mips_mem_pkg::mem_addr_w-1:0] addr;
	logic [mips_isa_pkg::word_w-1:0] wdata;
	// valid while ack is high
	logic [mips_isa_pkg::word_w-1:0] rdata;

	modport requester (output req, we, addr, wdata, input ack, rdata);
	modport responder (input req, we, addr, wdata, output ack, rdata);
endinterface

// instruction hand-off from fetch to execute
// transfer on instr_valid && ready, redirect is a one-cycle pulse
interface fetch_if;
	logic instr_valid;
	logic [mips_isa_pkg::word_w-1:0] instr;
	logic ready;
	logic redirect;
	logic [mips_mem_pkg::mem_addr_w-1:0] target;

	modport source (output instr_valid, instr, input ready, redirect, target);
	modport sink (input instr_valid, instr, output ready, redirect, target);
endinterface

/* logic/unified_mem.sv */
module unified_mem (
	input logic clk,
	input logic rst_n,
	mem_port_if.responder bus,
	// host preload, used while start is low
	input logic host_we,
	input logic [mips_mem_pkg::mem_addr_w-1:0] host_addr,
	input logic [mips_isa_pkg::word_w-1:0] host_data
);

	// program and data share one array
	logic [mips_isa_pkg::word_w-1:0] mem [mips_mem_pkg::mem_depth];
	// new request seen, ack not yet given
	logic accept;

	assign accept = bus.req && !bus.ack;

	////////////////////
	// handshake
	////////////////////

	// ack follows req with one cycle of delay, both edges
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			bus.ack <= 1'b0;
		else if (accept)
			bus.ack <= 1'b1;
		else if (!bus.req && bus.ack)
			bus.ack <= 1'b0;
	end

	////////////////////
	// storage
	////////////////////

	// host write wins, bus is idle during preload anyway
	always_ff @(posedge clk)
	begin
		if (host_we)
			mem[host_addr] <= host_data;
		else if (accept && bus.we)
			mem[bus.addr] <= bus.wdata;
	end

	// read data registered with the rising ack
	always_ff @(posedge clk)
	begin
		if (accept)
			bus.rdata <= mem[bus.addr];
	end

endmodule

/* logic/mem_arbiter.sv */
module mem_arbiter (
	input logic clk,
	input logic rst_n,
	mem_port_if.responder fetch_port,
	mem_port_if.responder lsu_port,
	mem_port_if.requester mem_bus
);

	// current owner of mem_bus
	mips_mem_pkg::requester_e grant;
	// bus idle, no leftover ack
	logic idle;

	assign idle = (grant == mips_mem_pkg::req_none) && !mem_bus.ack;

	////////////////////
	// grant register
	////////////////////

	// lsu first, locked for a whole four-phase cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			grant <= mips_mem_pkg::req_none;
		else if (idle)
		begin
			if (lsu_port.req)
				grant <= mips_mem_pkg::req_lsu;
			else if (fetch_port.req)
				grant <= mips_mem_pkg::req_fetch;
		end
		// req already low and ack now low, transaction over
		else if (!mem_bus.req && !mem_bus.ack)
			grant <= mips_mem_pkg::req_none;
	end

	////////////////////
	// port mux
	////////////////////

	always_comb
	begin
		mem_bus.req = 1'b0;
		mem_bus.we = 1'b0;
		mem_bus.addr = '0;
		mem_bus.wdata = '0;
		// losing port sees ack low and stalls
		fetch_port.ack = 1'b0;
		fetch_port.rdata = '0;
		lsu_port.ack = 1'b0;
		lsu_port.rdata = '0;
		case (grant)
			mips_mem_pkg::req_fetch:
			begin
				mem_bus.req = fetch_port.req;
				mem_bus.we = fetch_port.we;
				mem_bus.addr = fetch_port.addr;
				mem_bus.wdata = fetch_port.wdata;
				fetch_port.ack = mem_bus.ack;
				fetch_port.rdata = mem_bus.rdata;
			end
			mips_mem_pkg::req_lsu:
			begin
				mem_bus.req = lsu_port.req;
				mem_bus.we = lsu_port.we;
				mem_bus.addr = lsu_port.addr;
				mem_bus.wdata = lsu_port.wdata;
				lsu_port.ack = mem_bus.ack;
				lsu_port.rdata = mem_bus.rdata;
			end
			default:
			begin
			end
		endcase
	end

endmodule

/* logic/fetch_unit.sv */
module fetch_unit (
	input logic clk,
	input logic rst_n,
	input logic start,
	mem_port_if.requester mem,
	fetch_if.source fetch
);

	// next word to fetch
	logic [mips_mem_pkg::mem_addr_w-1:0] pc;
	// address of the fetch on the bus
	logic [mips_mem_pkg::mem_addr_w-1:0] addr_q;
	// req dropped, waiting for ack low
	logic wait_fall;
	// in-flight response was cancelled by a redirect
	logic drop;
	logic held_valid;
	logic [mips_isa_pkg::word_w-1:0] held_instr;
	logic resp;
	logic launch;

	// response arrives this cycle
	assign resp = mem.req && mem.ack;
	// one held, one in flight at most
	assign launch = start && !mem.req && !wait_fall && !held_valid && !mem.ack && !fetch.redirect;

	// fetch only reads
	assign mem.we = 1'b0;
	assign mem.wdata = '0;
	assign mem.addr = addr_q;
	assign fetch.instr_valid = held_valid;
	assign fetch.instr = held_instr;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pc <= '0;
			mem.req <= 1'b0;
			wait_fall <= 1'b0;
			drop <= 1'b0;
			held_valid <= 1'b0;
		end
		else
		begin
			// redirect beats the sequential advance
			if (fetch.redirect)
				pc <= fetch.target;
			else if (launch)
				pc <= pc + 1'b1;
			if (launch)
				mem.req <= 1'b1;
			else if (resp)
				mem.req <= 1'b0;
			if (resp)
				wait_fall <= 1'b1;
			else if (wait_fall && !mem.ack)
				wait_fall <= 1'b0;
			// cancelled fetch still completes, data discarded
			if (resp)
				drop <= 1'b0;
			else if (mem.req && fetch.redirect)
				drop <= 1'b1;
			if (fetch.redirect)
				held_valid <= 1'b0;
			else if (resp && !drop)
				held_valid <= 1'b1;
			else if (held_valid && fetch.ready)
				held_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (launch)
			addr_q <= pc;
		if (resp)
			held_instr <= mem.rdata;
	end

endmodule

/* logic/exec_unit.sv */
module exec_unit (
	input logic clk,
	input logic rst_n,
	mem_port_if.requester mem,
	fetch_if.sink fetch,
	input logic [mips_isa_pkg::reg_addr_w-1:0] dbg_reg_addr,
	output logic [mips_isa_pkg::word_w-1:0] dbg_reg_data,
	output logic halted
);

	mips_isa_pkg::exec_state_e state;
	logic [mips_isa_pkg::word_w-1:0] ir;
	// pc of the next instruction, tracks the fetch stream
	logic [mips_mem_pkg::mem_addr_w-1:0] pc_q;
	logic [mips_isa_pkg::word_w-1:0] regs [mips_isa_pkg::num_regs];

	// decoded fields
	mips_isa_pkg::opcode_e opcode;
	mips_isa_pkg::funct_e funct;
	logic [mips_isa_pkg::reg_addr_w-1:0] rs;
	logic [mips_isa_pkg::reg_addr_w-1:0] rt;
	logic [mips_isa_pkg::reg_addr_w-1:0] rd;
	logic [mips_isa_pkg::imm_w-1:0] imm;
	logic [mips_isa_pkg::word_w-1:0] imm_sext;
	logic [mips_isa_pkg::word_w-1:0] rs_val;
	logic [mips_isa_pkg::word_w-1:0] rt_val;
	// addiu result and lw/sw address
	logic [mips_isa_pkg::word_w-1:0] sum_imm;
	logic [mips_isa_pkg::word_w-1:0] alu_y;
	logic alu_ok;
	logic take_branch;
	logic wr_en;
	logic [mips_isa_pkg::reg_addr_w-1:0] wr_addr;
	logic [mips_isa_pkg::word_w-1:0] wr_data;

	assign opcode = mips_isa_pkg::opcode_e'(ir[31:26]);
	assign rs = ir[25:21];
	assign rt = ir[20:16];
	assign rd = ir[15:11];
	assign funct = mips_isa_pkg::funct_e'(ir[5:0]);
	assign imm = ir[15:0];
	assign imm_sext = {{(mips_isa_pkg::word_w - mips_isa_pkg::imm_w){imm[mips_isa_pkg::imm_w-1]}}, imm};
	// r0 is never written, reads as zero
	assign rs_val = regs[rs];
	assign rt_val = regs[rt];
	assign sum_imm = rs_val + imm_sext;

	////////////////////
	// ALU and branch
	////////////////////

	always_comb
	begin
		alu_y = '0;
		alu_ok = 1'b1;
		case (funct)
			mips_isa_pkg::fn_addu: alu_y = rs_val + rt_val;
			mips_isa_pkg::fn_subu: alu_y = rs_val - rt_val;
			mips_isa_pkg::fn_and: alu_y = rs_val & rt_val;
			mips_isa_pkg::fn_or: alu_y = rs_val | rt_val;
			mips_isa_pkg::fn_slt: alu_y = {{(mips_isa_pkg::word_w-1){1'b0}}, $signed(rs_val) < $signed(rt_val)};
			// unknown funct, no operation
			default: alu_ok = 1'b0;
		endcase
	end

	assign take_branch = (state == mips_isa_pkg::st_execute) && (opcode == mips_isa_pkg::op_beq)
		&& (rs_val == rt_val);
	// pc_q already holds pc + 1
	assign fetch.target = pc_q + imm_sext[mips_mem_pkg::mem_addr_w-1:0];
	assign fetch.redirect = take_branch;
	assign fetch.ready = (state == mips_isa_pkg::st_wait_instr);
	assign halted = (state == mips_isa_pkg::st_halted);
	assign dbg_reg_data = regs[dbg_reg_addr];

	////////////////////
	// register file
	////////////////////

	// single write port, lw data taken while ack is high
	always_comb
	begin
		wr_en = 1'b0;
		wr_addr = rd;
		wr_data = alu_y;
		if (state == mips_isa_pkg::st_execute && opcode == mips_isa_pkg::op_rtype)
			wr_en = alu_ok;
		else if (state == mips_isa_pkg::st_execute && opcode == mips_isa_pkg::op_addiu)
		begin
			wr_en = 1'b1;
			wr_addr = rt;
			wr_data = sum_imm;
		end
		else if (state == mips_isa_pkg::st_mem_req && mem.ack && opcode == mips_isa_pkg::op_lw)
		begin
			wr_en = 1'b1;
			wr_addr = rt;
			wr_data = mem.rdata;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < mips_isa_pkg::num_regs; i++)
				regs[i] <= '0;
		end
		else if (wr_en && wr_addr != '0)
			regs[wr_addr] <= wr_data;
	end

	////////////////////
	// execute FSM
	////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= mips_isa_pkg::st_wait_instr;
			pc_q <= '0;
			mem.req <= 1'b0;
		end
		else
		begin
			case (state)
				mips_isa_pkg::st_wait_instr:
					if (fetch.instr_valid)
					begin
						state <= mips_isa_pkg::st_execute;
						pc_q <= pc_q + 1'b1;
					end
				mips_isa_pkg::st_execute:
					case (opcode)
						mips_isa_pkg::op_lw, mips_isa_pkg::op_sw:
						begin
							mem.req <= 1'b1;
							state <= mips_isa_pkg::st_mem_req;
						end
						mips_isa_pkg::op_beq:
						begin
							if (take_branch)
								pc_q <= fetch.target;
							state <= mips_isa_pkg::st_wait_instr;
						end
						mips_isa_pkg::op_halt: state <= mips_isa_pkg::st_halted;
						default: state <= mips_isa_pkg::st_wait_instr;
					endcase
				// hold req until the memory answers
				mips_isa_pkg::st_mem_req:
					if (mem.ack)
					begin
						mem.req <= 1'b0;
						state <= mips_isa_pkg::st_mem_release;
					end
				mips_isa_pkg::st_mem_release:
					if (!mem.ack)
						state <= mips_isa_pkg::st_wait_instr;
				// halted stays until reset
				mips_isa_pkg::st_halted: state <= mips_isa_pkg::st_halted;
				default: state <= mips_isa_pkg::st_wait_instr;
			endcase
		end
	end

	// payload, loaded while req is low
	always_ff @(posedge clk)
	begin
		if (state == mips_isa_pkg::st_wait_instr && fetch.instr_valid)
			ir <= fetch.instr;
		if (state == mips_isa_pkg::st_execute)
		begin
			mem.we <= (opcode == mips_isa_pkg::op_sw);
			mem.addr <= sum_imm[mips_mem_pkg::mem_addr_w-1:0];
			mem.wdata <= rt_val;
		end
	end

endmodule

/* logic/mips_top.sv */
module mips_top (
	input logic clk,
	input logic rst_n,
	input logic start,
	// host program load
	input logic prog_we,
	input logic [mips_mem_pkg::mem_addr_w-1:0] prog_addr,
	input logic [mips_isa_pkg::word_w-1:0] prog_data,
	// register readback
	input logic [mips_isa_pkg::reg_addr_w-1:0] dbg_reg_addr,
	output logic [mips_isa_pkg::word_w-1:0] dbg_reg_data,
	output logic halted
);

	// fetch and lsu share the memory through the arbiter
	mem_port_if fetch_port ();
	mem_port_if lsu_port ();
	mem_port_if mem_bus ();
	fetch_if fetch_link ();

	unified_mem u_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.bus       (mem_bus.responder),
		.host_we   (prog_we),
		.host_addr (prog_addr),
		.host_data (prog_data)
	);

	mem_arbiter u_arb (
		.clk        (clk),
		.rst_n      (rst_n),
		.fetch_port (fetch_port.responder),
		.lsu_port   (lsu_port.responder),
		.mem_bus    (mem_bus.requester)
	);

	fetch_unit u_fetch (
		.clk   (clk),
		.rst_n (rst_n),
		.start (start),
		.mem   (fetch_port.requester),
		.fetch (fetch_link.source)
	);

	exec_unit u_exec (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem          (lsu_port.requester),
		.fetch        (fetch_link.sink),
		.dbg_reg_addr (dbg_reg_addr),
		.dbg_reg_data (dbg_reg_data),
		.halted       (halted)
	);

endmodule

/* verification/tb_clock_gen.sv */
module tb_clock_gen (
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	// 20 ns period, even duty
	localparam int half_period = 10;

	initial
	begin
		clk = 1'b0;
		forever
			#half_period clk = ~clk;
	end

endmodule

/* verification/mips_chk.sv */
module mips_chk (
	input logic clk,
	input logic rst_n,
	input logic fetch_req,
	input logic fetch_ack,
	input logic lsu_req,
	input logic lsu_ack,
	input logic mem_req,
	input logic mem_ack,
	input mips_mem_pkg::requester_e grant,
	input logic halted
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	////////////////////
	// four-phase, fetch port
	////////////////////

	a_fetch_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_req && !fetch_ack |=> fetch_req)
	else
	begin
		$error("fetch_port req fell before ack rose");
		fail_count++;
	end

	a_fetch_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_req && fetch_ack |=> fetch_ack)
	else
	begin
		$error("fetch_port ack fell before req fell");
		fail_count++;
	end

	////////////////////
	// four-phase, lsu port
	////////////////////

	a_lsu_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		lsu_req && !lsu_ack |=> lsu_req)
	else
	begin
		$error("lsu_port req fell before ack rose");
		fail_count++;
	end

	a_lsu_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
		lsu_req && lsu_ack |=> lsu_ack)
	else
	begin
		$error("lsu_port ack fell before req fell");
		fail_count++;
	end

	////////////////////
	// shared bus into unified_mem
	////////////////////

	a_mem_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req && !mem_ack |=> mem_req)
	else
	begin
		$error("mem_bus req fell before ack rose");
		fail_count++;
	end

	a_mem_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req && mem_ack |=> mem_ack)
	else
	begin
		$error("mem_bus ack fell before req fell");
		fail_count++;
	end

	// owner locked while the memory still acks
	a_grant_locked: assert property (@(posedge clk) disable iff (!rst_n)
		mem_ack |=> $stable(grant))
	else
	begin
		$error("arbiter grant changed while mem_bus ack was high");
		fail_count++;
	end

	// halted only clears through reset
	a_halt_sticky: assert property (@(posedge clk)
		halted && rst_n |=> halted)
	else
	begin
		$error("halted fell without a reset");
		fail_count++;
	end

endmodule

// arbiter ports, memory bus and halt all visible from the top level
bind mips_top mips_chk u_chk (
	.clk       (clk),
	.rst_n     (rst_n),
	.fetch_req (fetch_port.req),
	.fetch_ack (fetch_port.ack),
	.lsu_req   (lsu_port.req),
	.lsu_ack   (lsu_port.ack),
	.mem_req   (mem_bus.req),
	.mem_ack   (mem_bus.ack),
	.grant     (u_arb.grant),
	.halted    (halted)
);

/* verification/mips_tb.sv */
module mips_tb;
	timeunit 1ns;
	timeprecision 100ps;

	typedef logic [mips_isa_pkg::word_w-1:0] word_t;
	typedef logic [mips_isa_pkg::reg_addr_w-1:0] reg_idx_t;
	typedef logic [mips_mem_pkg::mem_addr_w-1:0] addr_t;

	localparam int clk_period = 20;
	localparam int drive_delay = 2;
	localparam int reset_cycles = 16;
	localparam int num_tests = 5;
	localparam int cycles_per_test = 2000;
	localparam int halt_limit = 1000;
	localparam int model_step_limit = 4000;
	// preloaded data lives well above the programs
	localparam int data_base = 192;
	localparam int store_base = 128;
	localparam int settle_cycles = 50;

	logic clk;
	logic rst_n;
	logic start;
	logic prog_we;
	addr_t prog_addr;
	word_t prog_data;
	reg_idx_t dbg_reg_addr;
	word_t dbg_reg_data;
	logic halted;

	int seed = 13902;
	int value_errors = 0;
	int other_errors = 0;
	// program image, word 0 first
	word_t prog_q [$];
	// reference model, memory mirrors every host write
	word_t model_mem [mips_mem_pkg::mem_depth];
	word_t model_regs [mips_isa_pkg::num_regs];

	tb_clock_gen u_clk_gen (
		.clk (clk)
	);

	mips_top DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.prog_we      (prog_we),
		.prog_addr    (prog_addr),
		.prog_data    (prog_data),
		.dbg_reg_addr (dbg_reg_addr),
		.dbg_reg_data (dbg_reg_data),
		.halted       (halted)
	);

	////////////////////
	// compare tasks
	////////////////////

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_reg_index(input string name, input reg_idx_t expected,
		input reg_idx_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	////////////////////
	// program building
	////////////////////

	function automatic word_t sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	task automatic emit_rtype(input mips_isa_pkg::funct_e fn, input int rd, input int rs,
		input int rt);
		prog_q.push_back({mips_isa_pkg::op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn});
	endtask

	task automatic emit_itype(input mips_isa_pkg::opcode_e op, input int rt, input int rs,
		input logic [15:0] imm);
		prog_q.push_back({op, 5'(rs), 5'(rt), imm});
	endtask

	task automatic emit_halt();
		prog_q.push_back({mips_isa_pkg::op_halt, 26'd0});
	endtask

	////////////////////
	// host and debug port access
	////////////////////

	// one word per cycle, prog_we left high until load_program ends
	task automatic host_write(input addr_t addr, input word_t data);
		@(posedge clk);
		#drive_delay;
		prog_we = 1'b1;
		prog_addr = addr;
		prog_data = data;
		model_mem[addr] = data;
	endtask

	task automatic prepare_memory();
		@(posedge clk);
		#drive_delay;
		start = 1'b0;
		prog_q.delete();
		// unused words decode as halt, low byte carries the address
		for (int a = 0; a < mips_mem_pkg::mem_depth; a++)
			host_write(addr_t'(a), {mips_isa_pkg::op_halt, 18'd0, addr_t'(a)});
	endtask

	task automatic load_program();
		foreach (prog_q[i])
			host_write(addr_t'(i), prog_q[i]);
		@(posedge clk);
		#drive_delay;
		prog_we = 1'b0;
	endtask

	task automatic pulse_reset();
		@(posedge clk);
		#drive_delay;
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#drive_delay;
		rst_n = 1'b1;
	endtask

	// register file is read combinationally, sampled mid-cycle
	task automatic read_reg(input reg_idx_t idx, output word_t val);
		@(posedge clk);
		#drive_delay;
		dbg_reg_addr = idx;
		@(negedge clk);
		val = dbg_reg_data;
	endtask

	task automatic wait_for_halt(input string test_name);
		int cycles;
		cycles = 0;
		while (halted !== 1'b1 && cycles < halt_limit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (halted !== 1'b1)
		begin
			$display("%s: core did not halt within %0d cycles", test_name, halt_limit);
			other_errors++;
		end
	endtask

	////////////////////
	// reference model
	////////////////////

	function automatic void write_model_reg(input reg_idx_t idx, input word_t val);
		// r0 hardwired to zero
		if (idx != '0)
			model_regs[idx] = val;
	endfunction

	// steps the image in model_mem from word 0 until halt
	task automatic run_model();
		addr_t pc;
		word_t w;
		word_t a;
		word_t b;
		word_t simm;
		word_t ea;
		mips_isa_pkg::opcode_e op;
		mips_isa_pkg::funct_e fn;
		int steps;
		bit done;
		pc = '0;
		steps = 0;
		done = 1'b0;
		foreach (model_regs[i])
			model_regs[i] = '0;
		while (!done && steps < model_step_limit)
		begin
			w = model_mem[pc];
			op = mips_isa_pkg::opcode_e'(w[31:26]);
			fn = mips_isa_pkg::funct_e'(w[5:0]);
			a = model_regs[w[25:21]];
			b = model_regs[w[20:16]];
			simm = sext16(w[15:0]);
			ea = a + simm;
			// beq offset is relative to pc + 1
			pc = pc + 1'b1;
			steps++;
			case (op)
				mips_isa_pkg::op_rtype:
					case (fn)
						mips_isa_pkg::fn_addu: write_model_reg(w[15:11], a + b);
						mips_isa_pkg::fn_subu: write_model_reg(w[15:11], a - b);
						mips_isa_pkg::fn_and: write_model_reg(w[15:11], a & b);
						mips_isa_pkg::fn_or: write_model_reg(w[15:11], a | b);
						mips_isa_pkg::fn_slt:
							write_model_reg(w[15:11], ($signed(a) < $signed(b)) ? 1 : 0);
						default: ;
					endcase
				mips_isa_pkg::op_addiu: write_model_reg(w[20:16], ea);
				mips_isa_pkg::op_lw: write_model_reg(w[20:16], model_mem[addr_t'(ea)]);
				mips_isa_pkg::op_sw: model_mem[addr_t'(ea)] = b;
				mips_isa_pkg::op_beq:
					if (a == b)
						pc = pc + addr_t'(simm);
				mips_isa_pkg::op_halt: done = 1'b1;
				default: ;
			endcase
		end
		if (!done)
		begin
			$display("reference model did not reach a halt instruction");
			other_errors++;
		end
	endtask

	task automatic compare_all_regs(input string tag);
		word_t val;
		for (int i = 0; i < mips_isa_pkg::num_regs; i++)
		begin
			read_reg(reg_idx_t'(i), val);
			check_word($sformatf("%s dbg_reg_data r%0d", tag, i), model_regs[i], val);
		end
	endtask

	// start low and program loaded before this point
	task automatic run_program(input string name);
		load_program();
		pulse_reset();
		@(posedge clk);
		#drive_delay;
		start = 1'b1;
		wait_for_halt(name);
		run_model();
		compare_all_regs(name);
	endtask

	////////////////////
	// directed tests
	////////////////////

	task automatic test_alu();
		logic [15:0] v1;
		logic [15:0] v2;
		word_t val;
		prepare_memory();
		v1 = 16'($random(seed));
		v2 = 16'($random(seed));
		emit_itype(mips_isa_pkg::op_addiu, 1, 0, v1);
		emit_itype(mips_isa_pkg::op_addiu, 2, 0, v2);
		// extremes for signed compare and wrap
		emit_itype(mips_isa_pkg::op_addiu, 3, 0, 16'h8000);
		emit_itype(mips_isa_pkg::op_addiu, 4, 0, 16'h7fff);
		emit_rtype(mips_isa_pkg::fn_addu, 5, 1, 2);
		emit_rtype(mips_isa_pkg::fn_subu, 6, 1, 2);
		emit_rtype(mips_isa_pkg::fn_and, 7, 1, 2);
		emit_rtype(mips_isa_pkg::fn_or, 8, 1, 2);
		emit_rtype(mips_isa_pkg::fn_slt, 9, 1, 2);
		emit_rtype(mips_isa_pkg::fn_slt, 10, 3, 4);
		emit_rtype(mips_isa_pkg::fn_slt, 11, 4, 3);
		emit_rtype(mips_isa_pkg::fn_addu, 12, 3, 3);
		emit_rtype(mips_isa_pkg::fn_subu, 13, 0, 4);
		emit_halt();
		run_program("alu");
		read_reg(10, val);
		check_word("dbg_reg_data r10 slt signed", 32'd1, val);
		read_reg(12, val);
		check_word("dbg_reg_data r12 addu wrap", 32'hffff0000, val);
		read_reg(13, val);
		check_word("dbg_reg_data r13 subu wrap", 32'hffff8001, val);
	endtask

	task automatic test_reg_zero();
		word_t val;
		prepare_memory();
		emit_itype(mips_isa_pkg::op_addiu, 0, 0, 16'd5);
		emit_itype(mips_isa_pkg::op_addiu, 1, 0, 16'd7);
		emit_rtype(mips_isa_pkg::fn_addu, 0, 1, 1);
		// r0 as a source after the writes
		emit_itype(mips_isa_pkg::op_addiu, 2, 0, 16'd3);
		emit_rtype(mips_isa_pkg::fn_addu, 3, 0, 1);
		emit_rtype(mips_isa_pkg::fn_or, 4, 0, 0);
		emit_halt();
		run_program("reg_zero");
		read_reg(0, val);
		check_word("dbg_reg_data r0", '0, val);
		read_reg(2, val);
		check_word("dbg_reg_data r2", 32'd3, val);
		read_reg(3, val);
		check_word("dbg_reg_data r3", 32'd7, val);
	endtask

	task automatic test_load_store();
		logic [15:0] v1;
		logic [15:0] v2;
		word_t stored [4];
		word_t val;
		prepare_memory();
		v1 = 16'($random(seed));
		v2 = 16'($random(seed));
		stored[0] = sext16(v1);
		stored[1] = sext16(v2);
		stored[2] = stored[0] + stored[1];
		stored[3] = stored[0] - stored[1];
		emit_itype(mips_isa_pkg::op_addiu, 1, 0, v1);
		emit_itype(mips_isa_pkg::op_addiu, 2, 0, v2);
		emit_rtype(mips_isa_pkg::fn_addu, 3, 1, 2);
		emit_rtype(mips_isa_pkg::fn_subu, 4, 1, 2);
		emit_itype(mips_isa_pkg::op_addiu, 10, 0, 16'(store_base));
		// next fetch is pending while each access runs
		for (int i = 0; i < 4; i++)
			emit_itype(mips_isa_pkg::op_sw, 1 + i, 10, 16'(i));
		for (int i = 0; i < 4; i++)
			emit_itype(mips_isa_pkg::op_lw, 11 + i, 10, 16'(i));
		emit_halt();
		run_program("load_store");
		for (int i = 0; i < 4; i++)
		begin
			read_reg(reg_idx_t'(11 + i), val);
			check_word($sformatf("dbg_reg_data r%0d loaded", 11 + i), stored[i], val);
		end
	endtask

	task automatic test_branch();
		int bound;
		word_t val;
		prepare_memory();
		bound = 2 + ($unsigned($random(seed)) % 8);
		emit_itype(mips_isa_pkg::op_addiu, 1, 0, 16'd5);
		emit_itype(mips_isa_pkg::op_addiu, 2, 0, 16'd5);
		// taken, skips words 3 and 4
		emit_itype(mips_isa_pkg::op_beq, 2, 1, 16'd2);
		emit_itype(mips_isa_pkg::op_addiu, 3, 0, 16'd99);
		emit_itype(mips_isa_pkg::op_addiu, 4, 0, 16'd99);
		// not taken, falls through
		emit_itype(mips_isa_pkg::op_beq, 0, 1, 16'd1);
		emit_itype(mips_isa_pkg::op_addiu, 5, 0, 16'd1);
		emit_itype(mips_isa_pkg::op_addiu, 6, 0, 16'(bound));
		emit_itype(mips_isa_pkg::op_addiu, 7, 0, 16'd0);
		// loop body at word 9
		emit_itype(mips_isa_pkg::op_addiu, 7, 7, 16'd1);
		emit_itype(mips_isa_pkg::op_addiu, 8, 8, 16'd3);
		emit_itype(mips_isa_pkg::op_beq, 6, 7, 16'd1);
		emit_itype(mips_isa_pkg::op_beq, 0, 0, 16'hfffc);
		emit_halt();
		emit_itype(mips_isa_pkg::op_addiu, 9, 0, 16'd77);
		run_program("branch");
		read_reg(7, val);
		check_word("dbg_reg_data r7 loop count", word_t'(bound), val);
		read_reg(8, val);
		check_word("dbg_reg_data r8 loop sum", word_t'(3 * bound), val);
		read_reg(3, val);
		check_word("dbg_reg_data r3 skipped", '0, val);
	endtask

	task automatic test_halt_preload();
		word_t data [4];
		word_t val;
		int dropped;
		prepare_memory();
		for (int i = 0; i < 4; i++)
		begin
			data[i] = word_t'($random(seed));
			host_write(addr_t'(data_base + i), data[i]);
		end
		for (int i = 0; i < 4; i++)
			emit_itype(mips_isa_pkg::op_lw, 1 + i, 0, 16'(data_base + i));
		emit_rtype(mips_isa_pkg::fn_addu, 5, 1, 2);
		// each of r20..r23 holds its own index
		for (int r = 20; r < 24; r++)
			emit_itype(mips_isa_pkg::op_addiu, r, 0, 16'(r));
		emit_halt();
		run_program("halt_preload");
		for (int i = 0; i < 4; i++)
		begin
			read_reg(reg_idx_t'(1 + i), val);
			check_word($sformatf("dbg_reg_data r%0d preload", 1 + i), data[i], val);
		end
		for (int r = 20; r < 24; r++)
		begin
			read_reg(reg_idx_t'(r), val);
			check_reg_index($sformatf("dbg_reg_data[4:0] r%0d", r), reg_idx_t'(r), val[4:0]);
		end
		dropped = 0;
		repeat (settle_cycles)
		begin
			@(negedge clk);
			if (halted !== 1'b1)
				dropped++;
		end
		if (dropped != 0)
		begin
			$display("halted went low on %0d cycles after the core had stopped", dropped);
			other_errors++;
		end
		// registers frozen after halt
		compare_all_regs("after_halt");
	endtask

	////////////////////
	// run control
	////////////////////

	initial
	begin
		rst_n = 1'b0;
		start = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		dbg_reg_addr = '0;
		repeat (reset_cycles) @(posedge clk);
		#drive_delay;
		rst_n = 1'b1;
		test_alu();
		test_reg_zero();
		test_load_store();
		test_branch();
		test_halt_preload();
		other_errors += DUT.u_chk.fail_count;
		$display("errors: %0d value mismatches, %0d other failures", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// budget for the whole run, tests times cycles per test
	initial
	begin
		#(num_tests * cycles_per_test * clk_period);
		$display("watchdog expired, the run did not finish within %0d cycles",
			num_tests * cycles_per_test);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

/* flist.f */
logic/mips_isa_pkg.sv
logic/mips_mem_pkg.sv
logic/mem_port_if.sv
logic/unified_mem.sv
logic/mem_arbiter.sv
logic/fetch_unit.sv
logic/exec_unit.sv
logic/mips_top.sv
verification/tb_clock_gen.sv
verification/mips_chk.sv
verification/mips_tb.sv

/* Bender.yml */
package:
  name: mips_subset

sources:
  - target: any(rtl, test)
    files:
      - logic/mips_isa_pkg.sv
      - logic/mips_mem_pkg.sv
      - logic/mem_port_if.sv
      - logic/unified_mem.sv
      - logic/mem_arbiter.sv
      - logic/fetch_unit.sv
      - logic/exec_unit.sv
      - logic/mips_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/mips_chk.sv
      - verification/mips_tb.sv
